// File: logic/asyncFifoGray.sv
/*
 * dual clock FIFO for pixel words
 *   binary pointers with extra wrap bit, Gray copies for crossing
 *   two-flop pointer synchronizers in each domain
 *   registered full on write side, registered empty on read side
 *   registered read data and valid
 */
`timescale 1ns/1ps
`include "pixelBuffer_defines.svh"

module asyncFifoGray (
    // write domain
    input  logic                writeClk,
    input  logic                reset,
    input  pixelPkg::pixelT     writeData,
    input  logic                writeEnable,
    output logic                full,
    // read domain
    input  logic                iPixelClk,
    fifoReadIf.fifoSide         fifo
);

    localparam int AW = `FIFO_ADDR_BITS;

    // dual port word storage
    logic [`PIXEL_WIDTH-1:0] storage [`FIFO_DEPTH];

    // write pointer set
    logic [AW:0] writeBin;
    logic [AW:0] writeGray;
    logic [AW:0] writeBinNext;
    logic [AW:0] writeGrayNext;
    logic [AW:0] readGraySync1;
    logic [AW:0] readGraySync2;
    logic        writePush;

    // read pointer set
    logic [AW:0] readBin;
    logic [AW:0] readGray;
    logic [AW:0] readBinNext;
    logic [AW:0] readGrayNext;
    logic [AW:0] writeGraySync1;
    logic [AW:0] writeGraySync2;
    logic        readPop;

    function automatic logic [AW:0] binToGray(input logic [AW:0] bin);
        binToGray = (bin >> 1) ^ bin;
    endfunction

    //------------------------------------------------------------
    // write domain
    //------------------------------------------------------------
    // push blocked while full so nothing is overwritten
    assign writePush     = writeEnable & ~full;
    assign writeBinNext  = writeBin + {{AW{1'b0}}, writePush};
    assign writeGrayNext = binToGray(writeBinNext);

    always_ff @(posedge writeClk)
    begin
        if (writePush)
        begin
            storage[writeBin[AW-1:0]] <= writeData;
        end
    end

    always_ff @(posedge writeClk)
    begin
        if (reset)
        begin
            writeBin      <= '0;
            writeGray     <= '0;
            readGraySync1 <= '0;
            readGraySync2 <= '0;
            full          <= 1'b0;
        end
        else
        begin
            writeBin      <= writeBinNext;
            writeGray     <= writeGrayNext;
            // read pointer into write domain
            readGraySync1 <= readGray;
            readGraySync2 <= readGraySync1;
            // full when pointers differ only in the two top Gray bits
            full <= (writeGrayNext ==
                     {~readGraySync2[AW:AW-1], readGraySync2[AW-2:0]});
        end
    end

    //------------------------------------------------------------
    // read domain
    //------------------------------------------------------------
    // request while empty pops nothing
    assign readPop      = fifo.readEnable & ~fifo.empty;
    assign readBinNext  = readBin + {{AW{1'b0}}, readPop};
    assign readGrayNext = binToGray(readBinNext);

    // data one cycle after the request
    always_ff @(posedge iPixelClk)
    begin
        if (readPop)
        begin
            fifo.readData <= pixelPkg::pixelT'(storage[readBin[AW-1:0]]);
        end
    end

    always_ff @(posedge iPixelClk)
    begin
        if (reset)
        begin
            readBin        <= '0;
            readGray       <= '0;
            writeGraySync1 <= '0;
            writeGraySync2 <= '0;
            fifo.empty     <= 1'b1;
            fifo.readValid <= 1'b0;
        end
        else
        begin
            readBin        <= readBinNext;
            readGray       <= readGrayNext;
            // write pointer into read domain
            writeGraySync1 <= writeGray;
            writeGraySync2 <= writeGraySync1;
            // empty on equal Gray pointers
            fifo.empty     <= (readGrayNext == writeGraySync2);
            fifo.readValid <= readPop;
        end
    end

endmodule

// File: logic/fifoReadIf.sv
/*
 * pixel domain read port of the async FIFO
 *   request, data, valid and empty signals
 *   modports for the FIFO and the timing generator
 */
`timescale 1ns/1ps

interface fifoReadIf;

    // one word requested per cycle
    logic               readEnable;
    // word popped last cycle
    pixelPkg::pixelT    readData;
    logic               readValid;
    // nothing left to pop
    logic               empty;

    modport fifoSide (
        input  readEnable,
        output readData,
        output readValid,
        output empty
    );

    // timing generator only needs request and empty
    modport timingSide (
        output readEnable,
        input  empty
    );

endinterface

// File: logic/pixelBufferTop.sv
/*
 * pixel buffer top level
 *   write side on baseClk, raster output on iPixelClk
 *   FIFO read interface between wrapper and timing generator
 */
`timescale 1ns/1ps

module pixelBufferTop (
    input  logic                baseClk,
    input  logic                iPixelClk,
    input  logic                reset,
    // producer side
    input  pixelPkg::pixelT     pixelIn,
    input  logic                pixelInValid,
    output logic                pixelInReady,
    // display side
    output pixelPkg::pixelT     pixelOut,
    output logic                dataEnable,
    output logic                hSync,
    output logic                vSync,
    output logic                underrun
);

    fifoReadIf pixelRead ();

    videoPkg::syncBundleT syncOut;

    pixelFifoWrapper pixelBuffer (
        .baseClk      (baseClk),
        .iPixelClk    (iPixelClk),
        .reset        (reset),
        .pixelIn      (pixelIn),
        .pixelInValid (pixelInValid),
        .pixelInReady (pixelInReady),
        .fifo         (pixelRead.fifoSide),
        .pixelOut     (pixelOut)
    );

    videoTiming timing (
        .iPixelClk (iPixelClk),
        .reset     (reset),
        .fifo      (pixelRead.timingSide),
        .sync      (syncOut),
        .underrun  (underrun)
    );

    // sync bundle onto plain ports
    assign dataEnable = syncOut.dataEnable;
    assign hSync      = syncOut.hSync;
    assign vSync      = syncOut.vSync;

endmodule

// File: logic/pixelBuffer_defines.svh
/*
 * pixel buffer build-time constants
 *   pixel word width
 *   async FIFO depth and pointer address bits
 *   horizontal and vertical raster timing
 */
`ifndef PIXELBUFFER_DEFINES_SVH
`define PIXELBUFFER_DEFINES_SVH

// pixel word with 8 bits per colour channel
`define PIXEL_WIDTH     24

// FIFO depth must be a power of two
`define FIFO_DEPTH      16
`define FIFO_ADDR_BITS  4

// horizontal timing in pixel columns with an exclusive sync end
`define H_ACTIVE        8
`define H_TOTAL         14
`define H_SYNC_START    10
`define H_SYNC_END      12

// vertical timing in lines with an exclusive sync end
`define V_ACTIVE        4
`define V_TOTAL         7
`define V_SYNC_START    5
`define V_SYNC_END      6

`endif

// File: logic/pixelFifoWrapper.sv
/*
 * pixel crossing wrapper
 *   valid/ready write adapter on baseClk
 *   async FIFO instance
 *   pixel domain output register, black on empty slots
 */
`timescale 1ns/1ps

module pixelFifoWrapper (
    input  logic                baseClk,
    input  logic                iPixelClk,
    input  logic                reset,
    input  pixelPkg::pixelT     pixelIn,
    input  logic                pixelInValid,
    output logic                pixelInReady,
    fifoReadIf.fifoSide         fifo,
    output pixelPkg::pixelT     pixelOut
);

    logic fifoFull;
    logic writeEnable;

    // ready straight from not full
    assign pixelInReady = ~fifoFull;
    // transfer on valid and ready
    assign writeEnable  = pixelInValid & pixelInReady;

    asyncFifoGray pixelFifo (
        .writeClk    (baseClk),
        .reset       (reset),
        .writeData   (pixelIn),
        .writeEnable (writeEnable),
        .full        (fifoFull),
        .iPixelClk   (iPixelClk),
        .fifo        (fifo)
    );

    //------------------------------------------------------------
    // output register
    //------------------------------------------------------------
    // new word on readValid, otherwise zero so underrun slots are black
    always_ff @(posedge iPixelClk)
    begin
        if (reset)
        begin
            pixelOut <= '0;
        end
        else if (fifo.readValid)
        begin
            pixelOut <= fifo.readData;
        end
        else
        begin
            pixelOut <= '0;
        end
    end

endmodule

// File: logic/pixelPkg.sv
/*
 * pixel word types
 *   colour channel type
 *   packed RGB pixel word
 */
`include "pixelBuffer_defines.svh"

package pixelPkg;

    // one colour channel is a third of the pixel word
    typedef logic [`PIXEL_WIDTH/3-1:0] channelT;

    // red in the top byte, blue in the bottom byte
    typedef struct packed {
        channelT red;
        channelT green;
        channelT blue;
    } pixelT;

endpackage

// File: logic/videoPkg.sv
/*
 * raster types
 *   column and line counter types
 *   sync bundle travelling with each pixel slot
 */
package videoPkg;

    // column counter covering H_TOTAL
    typedef logic [3:0] hCountT;

    // line counter covering V_TOTAL
    typedef logic [3:0] vCountT;

    // enable and sync flags for one raster position
    typedef struct packed {
        logic dataEnable;
        logic hSync;
        logic vSync;
    } syncBundleT;

endpackage

// File: logic/videoTiming.sv
/*
 * video timing generator
 *   column and line counters over the full raster
 *   one FIFO read per active position
 *   sync bundle delayed to line up with the output register
 *   sticky underrun flag
 */
`timescale 1ns/1ps
`include "pixelBuffer_defines.svh"

module videoTiming (
    input  logic                iPixelClk,
    input  logic                reset,
    fifoReadIf.timingSide       fifo,
    output videoPkg::syncBundleT sync,
    output logic                underrun
);

    videoPkg::hCountT     hCount;
    videoPkg::vCountT     vCount;
    videoPkg::syncBundleT nextBundle;
    // bundle for the position being requested now
    videoPkg::syncBundleT syncCurrent;
    videoPkg::syncBundleT syncDelay;

    // flags for the current counter position
    always_comb
    begin
        nextBundle.dataEnable = (hCount < `H_ACTIVE) && (vCount < `V_ACTIVE);
        // sync end exclusive
        nextBundle.hSync = (hCount >= `H_SYNC_START) && (hCount < `H_SYNC_END);
        nextBundle.vSync = (vCount >= `V_SYNC_START) && (vCount < `V_SYNC_END);
    end

    // read request in the same cycle as the current bundle
    assign fifo.readEnable = syncCurrent.dataEnable;

    //------------------------------------------------------------
    // raster counters and sync pipeline
    //------------------------------------------------------------
    always_ff @(posedge iPixelClk)
    begin
        if (reset)
        begin
            hCount      <= '0;
            vCount      <= '0;
            syncCurrent <= '0;
            syncDelay   <= '0;
            sync        <= '0;
        end
        else
        begin
            syncCurrent <= nextBundle;
            // two stages match the FIFO read and the output register
            syncDelay   <= syncCurrent;
            sync        <= syncDelay;
            if (hCount == `H_TOTAL - 1)
            begin
                hCount <= '0;
                vCount <= (vCount == `V_TOTAL - 1) ? '0 : vCount + 1'b1;
            end
            else
            begin
                hCount <= hCount + 1'b1;
            end
        end
    end

    // set when a request meets empty and held until reset
    always_ff @(posedge iPixelClk)
    begin
        if (reset)
            underrun <= 1'b0;
        else if (fifo.readEnable && fifo.empty)
            underrun <= 1'b1;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the pixel buffer testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module pixelBufferTb \
    -o pixelBufferSim \
    && ./obj_dir/pixelBufferSim | tee /dev/stderr | grep -qx "Testbench passed" \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }

// File: tb/pixelBufferTb.sv
/*
 * pixel buffer testbench
 *   pixel and base clocks, reset
 *   random valid/ready producer feeding a queue model
 *   raster geometry, pixel data, back-pressure and underrun checks
 */
`timescale 1ns/1ps
`include "pixelBuffer_defines.svh"

module pixelBufferTb;

    localparam int FRAME_CYCLES  = `H_TOTAL * `V_TOTAL;
    // three lines of active video drain a full FIFO
    localparam int IDLE_CYCLES   = 3 * `H_TOTAL;
    localparam int START_TIMEOUT = 50;
    localparam int RUN_TIMEOUT   = 4 * FRAME_CYCLES;

    logic            baseClk = 1'b0;
    logic            iPixelClk = 1'b0;
    logic            reset = 1'b1;
    pixelPkg::pixelT pixelIn = '0;
    logic            pixelInValid = 1'b0;
    logic            pixelInReady;
    pixelPkg::pixelT pixelOut;
    logic            dataEnable;
    logic            hSync;
    logic            vSync;
    logic            underrun;

    // accepted pixels not yet on the display
    pixelPkg::pixelT modelQueue[$];
    logic [31:0]     randomWord;
    logic            sawReadyLow = 1'b0;

    // raster position of the pixel now on the outputs
    videoPkg::hCountT column = '0;
    videoPkg::vCountT line = '0;
    int   frameCount = 0;
    logic started = 1'b0;
    logic afterReset = 1'b0;
    logic warmedUp = 1'b0;
    logic idleStarted = 1'b0;
    int   idleLeft = 0;
    int   underrunDelay = 0;
    logic underrunHold = 1'b0;
    logic underrunSlotSeen = 1'b0;
    int   pixelsChecked = 0;
    int   mismatchCount = 0;
    int   checkerFailures = 0;
    int   runFailures = 0;
    int   waitCycles;

    pixelBufferTop uut (
        .baseClk      (baseClk),
        .iPixelClk    (iPixelClk),
        .reset        (reset),
        .pixelIn      (pixelIn),
        .pixelInValid (pixelInValid),
        .pixelInReady (pixelInReady),
        .pixelOut     (pixelOut),
        .dataEnable   (dataEnable),
        .hSync        (hSync),
        .vSync        (vSync),
        .underrun     (underrun)
    );

    // 40 ns pixel clock
    always #20 iPixelClk = ~iPixelClk;

    // 24 ns base clock with an odd phase so no edge meets a pixel clock edge
    initial
    begin
        #5;
        forever #12 baseClk = ~baseClk;
    end

    //------------------------------------------------------------
    // producer on baseClk
    //------------------------------------------------------------
    always @(posedge baseClk)
    begin
        if (reset)
        begin
            pixelInValid <= 1'b0;
        end
        else
        begin
            // transfer the DUT takes on this edge
            if (pixelInValid && pixelInReady)
            begin
                modelQueue.push_back(pixelIn);
            end
            if (!pixelInReady)
            begin
                sawReadyLow = 1'b1;
            end
            // stalled word stays put
            if (!(pixelInValid && !pixelInReady))
            begin
                randomWord = $urandom;
                // never zero since zero marks an empty slot
                pixelIn      <= {randomWord[`PIXEL_WIDTH-1:1], 1'b1};
                pixelInValid <= (idleLeft == 0) && (($urandom % 10) < 7);
            end
        end
    end

    //------------------------------------------------------------
    // checker tasks
    //------------------------------------------------------------
    task automatic expectResetState(input string when);
        assert (!dataEnable && !hSync && !vSync && !underrun && pixelOut == '0
                && pixelInReady)
        else
        begin
            mismatchCount++;
            $display("MISMATCH at %0t: outputs %s de %b hs %b vs %b ur %b pix %h rdy %b",
                     $time, when, dataEnable, hSync, vSync, underrun, pixelOut,
                     pixelInReady);
        end
    endtask

    task automatic comparePixel();
        pixelPkg::pixelT expected;
        if (modelQueue.size() == 0)
        begin
            // nothing accepted so the slot must be black
            assert (pixelOut == '0)
            else
            begin
                mismatchCount++;
                $display("MISMATCH at %0t: empty slot expected 000000 got %h",
                         $time, pixelOut);
            end
            if (idleStarted)
                underrunSlotSeen = 1'b1;
            if (!underrunHold && underrunDelay == 0)
                underrunDelay = 2;
        end
        else if (pixelOut != '0)
        begin
            expected = modelQueue.pop_front();
            pixelsChecked++;
            assert (pixelOut == expected)
            else
            begin
                mismatchCount++;
                $display("MISMATCH at %0t: pixel expected %h got %h",
                         $time, expected, pixelOut);
            end
        end
        else
        begin
            // black slot allowed while a pixel may still be crossing
            assert (!warmedUp || idleStarted)
            else
            begin
                mismatchCount++;
                $display("MISMATCH at %0t: pixel expected %h got 000000",
                         $time, modelQueue[0]);
            end
        end
    endtask

    task automatic trackRaster();
        logic expEnable;
        logic expHSync;
        logic expVSync;
        if (!started && dataEnable)
            started = 1'b1;
        if (!started)
        begin
            // blanking ahead of the first enable
            assert (!hSync && !vSync)
            else
            begin
                mismatchCount++;
                $display("MISMATCH at %0t: sync before first enable hs %b vs %b",
                         $time, hSync, vSync);
            end
        end
        else
        begin
            expEnable = (column < `H_ACTIVE) && (line < `V_ACTIVE);
            expHSync  = (column >= `H_SYNC_START) && (column < `H_SYNC_END);
            expVSync  = (line >= `V_SYNC_START) && (line < `V_SYNC_END);
            assert (dataEnable == expEnable && hSync == expHSync && vSync == expVSync)
            else
            begin
                mismatchCount++;
                $display("MISMATCH at %0t: column %0d line %0d expected %b%b%b got %b%b%b",
                         $time, column, line, expEnable, expHSync, expVSync,
                         dataEnable, hSync, vSync);
            end
            // underrun due two cycles after an empty slot and sticky from then on
            if (underrunDelay > 0)
            begin
                underrunDelay--;
                if (underrunDelay == 0)
                    underrunHold = 1'b1;
            end
            if (underrunHold)
            begin
                assert (underrun)
                else
                begin
                    mismatchCount++;
                    $display("MISMATCH at %0t: underrun expected 1 got 0", $time);
                end
            end
            if (dataEnable)
                comparePixel();
            // FIFO entries plus the word waiting in the read register
            assert (modelQueue.size() <= `FIFO_DEPTH + 1)
            else
            begin
                checkerFailures++;
                $display("%0t: producer is %0d pixels ahead, more than the FIFO holds",
                         $time, modelQueue.size());
            end
            // idle phase from the start of the second frame
            if (idleLeft > 0)
                idleLeft--;
            else if (frameCount == 1 && !idleStarted)
            begin
                idleStarted = 1'b1;
                idleLeft    = IDLE_CYCLES;
            end
            if (column == `H_TOTAL - 1)
            begin
                column   = '0;
                warmedUp = 1'b1;
                if (line == `V_TOTAL - 1)
                begin
                    line = '0;
                    frameCount++;
                end
                else
                    line = line + 1'b1;
            end
            else
                column = column + 1'b1;
        end
    endtask

    // outputs sampled mid cycle
    always @(negedge iPixelClk)
    begin
        if (reset)
        begin
            expectResetState("during reset");
            afterReset = 1'b1;
        end
        else if (afterReset)
        begin
            expectResetState("after reset");
            afterReset = 1'b0;
        end
        else
            trackRaster();
    end

    //------------------------------------------------------------
    // run control
    //------------------------------------------------------------
    initial
    begin
        void'($urandom(63));
        repeat (10) @(posedge iPixelClk);
        reset <= 1'b0;
        waitCycles = 0;
        while (!started && waitCycles < START_TIMEOUT)
        begin
            @(posedge iPixelClk);
            waitCycles++;
        end
        assert (started)
        else
        begin
            runFailures++;
            $display("timeout: no data enable after reset");
        end
        waitCycles = 0;
        while (started && frameCount < 3 && waitCycles < RUN_TIMEOUT)
        begin
            @(posedge iPixelClk);
            waitCycles++;
        end
        assert (frameCount >= 3)
        else
        begin
            runFailures++;
            $display("timeout: raster did not complete three frames");
        end
        assert (sawReadyLow)
        else
        begin
            runFailures++;
            $display("pixelInReady never fell while the producer ran ahead");
        end
        assert (underrunSlotSeen)
        else
        begin
            runFailures++;
            $display("idle phase never produced an empty active slot");
        end
        $display("pixels checked %0d, mismatches %0d, checker failures %0d, run failures %0d",
                 pixelsChecked, mismatchCount, checkerFailures, runFailures);
        if (mismatchCount + checkerFailures + runFailures == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/pixelPkg.sv
logic/videoPkg.sv
logic/fifoReadIf.sv
logic/asyncFifoGray.sv
logic/pixelFifoWrapper.sv
logic/videoTiming.sv
logic/pixelBufferTop.sv
tb/pixelBufferTb.sv
